//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = cnn_load_ctrl_tb
FILELIST  = sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

//--- sim/cnn_load_ctrl_tb.sv
`timescale 1ns/10ps
`include "cnn_load_macros.svh"

module cnn_load_ctrl_tb
	import cnn_load_pkg::*;
;

localparam int total_writes = 6 + 3073 + 44 + 1944 + 2002 + 900;

logic clk;
logic rst;
logic [`CNN_BUS_W-1:0] awaddr;
logic awvalid;
logic [`CNN_BUS_W-1:0] wdata;
logic wvalid;
logic [`CNN_IMAGE_SET_W-1:0] image_set_q;
logic image_set_wr, irq_clear;
logic [`CNN_IMAGE_SET_W-1:0] image_set_data;
logic pixel_wr, pixel_done, bias_wr, bias_done;
logic weight_wr, l7_weight_wr, weight_done;
logic [2:0] l7_bank_sel;
logic [`CNN_MEM_W-1:0] pixel_addr, pixel_data, bias_addr, bias_data, weight_addr, weight_data;
layer_id_e bias_layer_sel;
layer_id_e weight_layer_sel;

int errors = 0;
int tests_run = 0;
int seed = 8;
string test_name = "reset";

// reference model state
int pix_idx, bias_layer, bias_idx, wt_layer, wt_idx;
logic [2:0] exp_bias_sel, exp_wt_sel;
int bias_cnt [5] = '{`CNN_BIAS_NUM, `CNN_BIAS_NUM, `CNN_BIAS_NUM, `CNN_BIAS_NUM,
	`CNN_L7_BIAS_NUM};
int wt_cnt [5] = '{`CNN_L1_WEIGHT_NUM, `CNN_L2_WEIGHT_NUM, `CNN_L4_WEIGHT_NUM,
	`CNN_L5_WEIGHT_NUM, `CNN_L7_WEIGHT_NUM};
int layer_num [5] = '{1, 2, 4, 5, 7};

// expected outputs for the current cycle
logic pix_hit, bias_hit, wt_hit, bias_act, wt_act, in_l7;
logic exp_pix_done, exp_bias_done, exp_wt_done, exp_img_wr, exp_irq;
logic [2:0] exp_bank;
logic [`CNN_MEM_W-1:0] exp_wt_addr;
logic [`CNN_IMAGE_SET_W-1:0] exp_img_data;

cnn_load_ctrl dut (.*);

initial
begin
	clk = 1'b0;
	forever #10 clk = ~clk;
end

always_comb
begin
	pix_hit       = wvalid && (awaddr[31:16] == `CNN_PIXEL_BASE);
	bias_hit      = wvalid && (awaddr[31:16] == `CNN_BIAS_BASE);
	wt_hit        = wvalid && (awaddr[31:16] == `CNN_WEIGHT_BASE);
	bias_act      = bias_hit && (bias_layer < 5);
	wt_act        = wt_hit && (wt_layer < 5);
	in_l7         = (wt_layer == 4);
	exp_pix_done  = pix_hit && (pix_idx == `CNN_PIXEL_NUM - 1);
	exp_bias_done = bias_act && (bias_idx == bias_cnt[bias_layer % 5] - 1);
	exp_wt_done   = wt_act && (wt_idx == wt_cnt[wt_layer % 5] - 1);
	exp_bank      = in_l7 ? 3'(wt_idx / `CNN_L7_BANK_SIZE + 1) : 3'd0;
	exp_wt_addr   = in_l7 ? 16'(wt_idx % `CNN_L7_BANK_SIZE) : 16'(wt_idx);
	exp_irq       = awvalid && (awaddr == `CNN_IRQ_ADDR);
	exp_img_wr    = (awvalid && (awaddr == `CNN_IMAGE_SET_ADDR)) || (image_set_q != 0);
	exp_img_data  = (awvalid && (awaddr == `CNN_IMAGE_SET_ADDR)) ? wdata[1:0] : 2'd0;
end

always_ff @(posedge clk or posedge rst)
begin
	if (rst)
	begin
		pix_idx <= 0;
		bias_layer <= 0;
		bias_idx <= 0;
		wt_layer <= 0;
		wt_idx <= 0;
		exp_bias_sel <= 3'd0;
		exp_wt_sel <= 3'd0;
	end
	else
	begin
		if (pix_hit)
			pix_idx <= exp_pix_done ? 0 : pix_idx + 1;
		if (exp_bias_done)
		begin
			exp_bias_sel <= 3'(layer_num[bias_layer]);
			bias_layer <= bias_layer + 1;
			bias_idx <= 0;
		end
		else if (bias_act)
			bias_idx <= bias_idx + 1;
		if (exp_wt_done)
		begin
			exp_wt_sel <= 3'(layer_num[wt_layer]);
			wt_layer <= wt_layer + 1;
			wt_idx <= 0;
		end
		else if (wt_act)
			wt_idx <= wt_idx + 1;
	end
end

task automatic report_mismatch(input string what, input int exp_val, input int act_val);
	errors++;
	$display("mismatch %s %s expected %0d actual %0d", test_name, what, exp_val, act_val);
endtask

a_pix_wr: assert property (@(posedge clk) disable iff (rst) pixel_wr == pix_hit)
	else report_mismatch("pixel_wr", int'($sampled(pix_hit)), int'($sampled(pixel_wr)));
a_pix_addr: assert property (@(posedge clk) disable iff (rst)
	!pix_hit || (pixel_addr == 16'(pix_idx)))
	else report_mismatch("pixel_addr", $sampled(pix_idx), int'($sampled(pixel_addr)));
a_pix_data: assert property (@(posedge clk) disable iff (rst)
	!pix_hit || (pixel_data == wdata[15:0]))
	else report_mismatch("pixel_data", int'($sampled(wdata[15:0])),
		int'($sampled(pixel_data)));
a_pix_done: assert property (@(posedge clk) disable iff (rst) pixel_done == exp_pix_done)
	else report_mismatch("pixel_done", int'($sampled(exp_pix_done)),
		int'($sampled(pixel_done)));
a_bias_wr: assert property (@(posedge clk) disable iff (rst) bias_wr == bias_act)
	else report_mismatch("bias_wr", int'($sampled(bias_act)), int'($sampled(bias_wr)));
a_bias_addr: assert property (@(posedge clk) disable iff (rst)
	!bias_act || (bias_addr == 16'(bias_idx)))
	else report_mismatch("bias_addr", $sampled(bias_idx), int'($sampled(bias_addr)));
a_bias_data: assert property (@(posedge clk) disable iff (rst)
	!bias_act || (bias_data == wdata[15:0]))
	else report_mismatch("bias_data", int'($sampled(wdata[15:0])),
		int'($sampled(bias_data)));
a_bias_done: assert property (@(posedge clk) disable iff (rst) bias_done == exp_bias_done)
	else report_mismatch("bias_done", int'($sampled(exp_bias_done)),
		int'($sampled(bias_done)));
a_bias_sel: assert property (@(posedge clk) disable iff (rst) bias_layer_sel == exp_bias_sel)
	else report_mismatch("bias_layer_sel", int'($sampled(exp_bias_sel)),
		int'($sampled(bias_layer_sel)));
a_wt_wr: assert property (@(posedge clk) disable iff (rst)
	(weight_wr == (wt_act && !in_l7)) && (l7_weight_wr == (wt_act && in_l7)))
	else report_mismatch("weight strobes", int'($sampled({wt_act && !in_l7, wt_act && in_l7})),
		int'($sampled({weight_wr, l7_weight_wr})));
a_bank: assert property (@(posedge clk) disable iff (rst) l7_bank_sel == exp_bank)
	else report_mismatch("l7_bank_sel", int'($sampled(exp_bank)), int'($sampled(l7_bank_sel)));
a_wt_addr: assert property (@(posedge clk) disable iff (rst)
	!wt_act || (weight_addr == exp_wt_addr))
	else report_mismatch("weight_addr", int'($sampled(exp_wt_addr)),
		int'($sampled(weight_addr)));
a_wt_data: assert property (@(posedge clk) disable iff (rst)
	!wt_act || (weight_data == wdata[15:0]))
	else report_mismatch("weight_data", int'($sampled(wdata[15:0])),
		int'($sampled(weight_data)));
a_wt_done: assert property (@(posedge clk) disable iff (rst) weight_done == exp_wt_done)
	else report_mismatch("weight_done", int'($sampled(exp_wt_done)),
		int'($sampled(weight_done)));
a_wt_sel: assert property (@(posedge clk) disable iff (rst) weight_layer_sel == exp_wt_sel)
	else report_mismatch("weight_layer_sel", int'($sampled(exp_wt_sel)),
		int'($sampled(weight_layer_sel)));
a_img_wr: assert property (@(posedge clk) disable iff (rst) image_set_wr == exp_img_wr)
	else report_mismatch("image_set_wr", int'($sampled(exp_img_wr)),
		int'($sampled(image_set_wr)));
a_img_data: assert property (@(posedge clk) disable iff (rst)
	!exp_img_wr || (image_set_data == exp_img_data))
	else report_mismatch("image_set_data", int'($sampled(exp_img_data)),
		int'($sampled(image_set_data)));
a_irq: assert property (@(posedge clk) disable iff (rst) irq_clear == exp_irq)
	else report_mismatch("irq_clear", int'($sampled(exp_irq)), int'($sampled(irq_clear)));

function automatic int lcg_next();
	seed = seed * 1103515245 + 12345;
	return seed;
endfunction

// one bus cycle, driven just after the clock edge
task automatic bus_cycle(input logic [31:0] addr, input logic aw, input logic w,
	input logic [1:0] set_q);
	@(posedge clk);
	#2;
	awaddr = addr;
	awvalid = aw;
	wvalid = w;
	wdata = lcg_next();
	image_set_q = set_q;
endtask

task automatic mem_writes(input logic [15:0] tag, input int count);
	for (int i = 0; i < count; i++)
		bus_cycle({tag, 16'(i)}, 1'b0, 1'b1, 2'd0);
endtask

task automatic end_test();
	bus_cycle(32'h0, 1'b0, 1'b0, 2'd0);
	tests_run++;
	$display("test %s finished, errors so far %0d", test_name, errors);
endtask

initial
begin
	rst = 1'b1;
	awaddr = '0;
	awvalid = 1'b0;
	wdata = '0;
	wvalid = 1'b0;
	image_set_q = '0;
	repeat (10) @(posedge clk);
	#2;
	rst = 1'b0;

	test_name = "registers";
	bus_cycle(`CNN_IMAGE_SET_ADDR, 1'b1, 1'b0, 2'd0);
	bus_cycle(32'h0, 1'b0, 1'b0, 2'd2);
	bus_cycle(`CNN_IRQ_ADDR, 1'b1, 1'b0, 2'd0);
	bus_cycle(32'h1234_0000, 1'b1, 1'b1, 2'd0);
	end_test();

	test_name = "pixel load";
	mem_writes(`CNN_PIXEL_BASE, `CNN_PIXEL_NUM + 1);
	end_test();

	test_name = "bias load";
	mem_writes(`CNN_BIAS_BASE, 44);
	end_test();

	test_name = "weight layers 1 to 5";
	mem_writes(`CNN_WEIGHT_BASE, 216 + 3 * 576);
	end_test();

	test_name = "weight layer 7";
	mem_writes(`CNN_WEIGHT_BASE, `CNN_L7_WEIGHT_NUM + 2);
	end_test();
	assert (weight_layer_sel == layer_7)
		else report_mismatch("weight_layer_sel", int'(layer_7), int'(weight_layer_sel));

	test_name = "interleaving";
	// restart all sequencers so every region takes writes again
	rst = 1'b1;
	repeat (10) @(posedge clk);
	#2;
	rst = 1'b0;
	for (int i = 0; i < 900; i++)
	begin
		case (i % 3)
			0: bus_cycle({16'(`CNN_PIXEL_BASE), 16'(i)}, 1'b0, 1'b1, 2'd0);
			1: bus_cycle({16'(`CNN_BIAS_BASE), 16'(i)}, 1'b0, 1'b1, 2'd0);
			default: bus_cycle({16'(`CNN_WEIGHT_BASE), 16'(i)}, 1'b0, 1'b1, 2'd0);
		endcase
	end
	end_test();

	$display("tests run %0d, errors %0d", tests_run, errors);
	if (errors == 0)
		$display("TEST PASS");
	else
		$display("TEST FAIL");
	$finish;
end

// run limit from the number of bus writes and both resets
initial
begin
	#(2 * total_writes * 20 + 2 * 10 * 20);
	$display("timeout, the tests did not finish in time");
	$display("TEST FAIL");
	$finish;
end

endmodule

//--- sources.f
+incdir+verilog
verilog/cnn_load_pkg.sv
verilog/load_addr_decoder.sv
verilog/pixel_store_seq.sv
verilog/bias_store_seq.sv
verilog/weight_store_seq.sv
verilog/cnn_load_ctrl.sv
sim/cnn_load_ctrl_tb.sv

//--- verilog/bias_store_seq.sv
`timescale 1ns/10ps
`include "cnn_load_macros.svh"

module bias_store_seq
	import cnn_load_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  bias_hit,
	input  logic [`CNN_MEM_W-1:0] mem_data,
	output logic                  bias_wr,
	output logic [`CNN_MEM_W-1:0] bias_addr,
	output logic [`CNN_MEM_W-1:0] bias_data,
	output logic                  bias_done,
	output layer_id_e             bias_layer_sel
);

store_state_e          state;
logic [`CNN_MEM_W-1:0] idx;
logic [`CNN_MEM_W-1:0] last_idx;
logic                  active;

// only the output layer has a different bias count
always_comb
begin
	case (state)
		st_layer7:
		begin
			last_idx = `CNN_MEM_W'(`CNN_L7_BIAS_NUM - 1);
		end
		default:
		begin
			last_idx = `CNN_MEM_W'(`CNN_BIAS_NUM - 1);
		end
	endcase
end

// hits after the last layer are dropped
assign active = bias_hit && (state != st_finish);

assign bias_wr   = active;
assign bias_addr = idx;
assign bias_data = mem_data;
assign bias_done = active && (idx == last_idx);

always_ff @(posedge clk or posedge rst)
begin
	if (rst)
	begin
		state          <= st_layer1;
		idx            <= '0;
		bias_layer_sel <= layer_none;
	end
	else if (bias_done)
	begin
		// layer complete, restart index for the next one
		state          <= next_layer(state);
		idx            <= '0;
		bias_layer_sel <= state_layer(state);
	end
	else if (active)
	begin
		idx <= idx + 1'b1;
	end
end

endmodule

//--- verilog/cnn_load_ctrl.sv
`timescale 1ns/10ps
`include "cnn_load_macros.svh"

module cnn_load_ctrl
	import cnn_load_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst,
	input  logic [`CNN_BUS_W-1:0]       awaddr,
	input  logic                        awvalid,
	input  logic [`CNN_BUS_W-1:0]       wdata,
	input  logic                        wvalid,
	input  logic [`CNN_IMAGE_SET_W-1:0] image_set_q,
	output logic                        image_set_wr,
	output logic [`CNN_IMAGE_SET_W-1:0] image_set_data,
	output logic                        irq_clear,
	output logic                        pixel_wr,
	output logic [`CNN_MEM_W-1:0]       pixel_addr,
	output logic [`CNN_MEM_W-1:0]       pixel_data,
	output logic                        pixel_done,
	output logic                        bias_wr,
	output logic [`CNN_MEM_W-1:0]       bias_addr,
	output logic [`CNN_MEM_W-1:0]       bias_data,
	output logic                        bias_done,
	output layer_id_e                   bias_layer_sel,
	output logic                        weight_wr,
	output logic                        l7_weight_wr,
	output logic [2:0]                  l7_bank_sel,
	output logic [`CNN_MEM_W-1:0]       weight_addr,
	output logic [`CNN_MEM_W-1:0]       weight_data,
	output logic                        weight_done,
	output layer_id_e                   weight_layer_sel
);

logic                  pixel_hit;
logic                  weight_hit;
logic                  bias_hit;
logic [`CNN_MEM_W-1:0] mem_data;

load_addr_decoder u_decoder (
	.awaddr         (awaddr),
	.awvalid        (awvalid),
	.wdata          (wdata),
	.wvalid         (wvalid),
	.image_set_q    (image_set_q),
	.pixel_hit      (pixel_hit),
	.weight_hit     (weight_hit),
	.bias_hit       (bias_hit),
	.mem_data       (mem_data),
	.image_set_wr   (image_set_wr),
	.image_set_data (image_set_data),
	.irq_clear      (irq_clear)
);

pixel_store_seq u_pixel_seq (
	.clk        (clk),
	.rst        (rst),
	.pixel_hit  (pixel_hit),
	.mem_data   (mem_data),
	.pixel_wr   (pixel_wr),
	.pixel_addr (pixel_addr),
	.pixel_data (pixel_data),
	.pixel_done (pixel_done)
);

bias_store_seq u_bias_seq (
	.clk            (clk),
	.rst            (rst),
	.bias_hit       (bias_hit),
	.mem_data       (mem_data),
	.bias_wr        (bias_wr),
	.bias_addr      (bias_addr),
	.bias_data      (bias_data),
	.bias_done      (bias_done),
	.bias_layer_sel (bias_layer_sel)
);

weight_store_seq u_weight_seq (
	.clk              (clk),
	.rst              (rst),
	.weight_hit       (weight_hit),
	.mem_data         (mem_data),
	.weight_wr        (weight_wr),
	.l7_weight_wr     (l7_weight_wr),
	.l7_bank_sel      (l7_bank_sel),
	.weight_addr      (weight_addr),
	.weight_data      (weight_data),
	.weight_done      (weight_done),
	.weight_layer_sel (weight_layer_sel)
);

endmodule

//--- verilog/cnn_load_macros.svh
`ifndef CNN_LOAD_MACROS_SVH
`define CNN_LOAD_MACROS_SVH

// bus and local memory widths
`define CNN_BUS_W 32
`define CNN_MEM_W 16
`define CNN_REGION_W 16

// region tags in the upper address half
`define CNN_PIXEL_BASE 16'hd555
`define CNN_WEIGHT_BASE 16'hd333
`define CNN_BIAS_BASE 16'hd444

// control registers, full address match
`define CNN_IMAGE_SET_ADDR 32'hd111_0000
`define CNN_IRQ_ADDR 32'hd222_0000
`define CNN_IMAGE_SET_W 2

// words per load
`define CNN_PIXEL_NUM 3072
`define CNN_L1_WEIGHT_NUM 216
`define CNN_L2_WEIGHT_NUM 576
`define CNN_L4_WEIGHT_NUM 576
`define CNN_L5_WEIGHT_NUM 576
`define CNN_L7_WEIGHT_NUM 2000
`define CNN_L7_BANK_SIZE 400
`define CNN_L7_BANK_NUM 5
`define CNN_BIAS_NUM 8
`define CNN_L7_BIAS_NUM 10

`endif

//--- verilog/cnn_load_pkg.sv
package cnn_load_pkg;

	// layer being filled by the weight and bias sequencers
	typedef enum logic [2:0] {
		st_layer1,
		st_layer2,
		st_layer4,
		st_layer5,
		st_layer7,
		st_finish
	} store_state_e;

	// last layer that is fully loaded
	typedef enum logic [2:0] {
		layer_none = 3'd0,
		layer_1    = 3'd1,
		layer_2    = 3'd2,
		layer_4    = 3'd4,
		layer_5    = 3'd5,
		layer_7    = 3'd7
	} layer_id_e;

	// layer order shared by both sequencers
	function automatic store_state_e next_layer(input store_state_e cur);
		case (cur)
			st_layer1: return st_layer2;
			st_layer2: return st_layer4;
			st_layer4: return st_layer5;
			st_layer5: return st_layer7;
			default:   return st_finish;
		endcase
	endfunction

	function automatic layer_id_e state_layer(input store_state_e cur);
		case (cur)
			st_layer1: return layer_1;
			st_layer2: return layer_2;
			st_layer4: return layer_4;
			st_layer5: return layer_5;
			st_layer7: return layer_7;
			default:   return layer_none;
		endcase
	endfunction

endpackage

//--- verilog/load_addr_decoder.sv
`timescale 1ns/10ps
`include "cnn_load_macros.svh"

module load_addr_decoder
(
	input  logic [`CNN_BUS_W-1:0]       awaddr,
	input  logic                        awvalid,
	input  logic [`CNN_BUS_W-1:0]       wdata,
	input  logic                        wvalid,
	input  logic [`CNN_IMAGE_SET_W-1:0] image_set_q,
	output logic                        pixel_hit,
	output logic                        weight_hit,
	output logic                        bias_hit,
	output logic [`CNN_MEM_W-1:0]       mem_data,
	output logic                        image_set_wr,
	output logic [`CNN_IMAGE_SET_W-1:0] image_set_data,
	output logic                        irq_clear
);

logic [`CNN_REGION_W-1:0] region;
logic                     image_set_sel;

assign region = awaddr[`CNN_BUS_W-1:`CNN_BUS_W-`CNN_REGION_W];

// memory regions, selected by the tag alone
assign pixel_hit  = wvalid && (region == `CNN_PIXEL_BASE);
assign weight_hit = wvalid && (region == `CNN_WEIGHT_BASE);
assign bias_hit   = wvalid && (region == `CNN_BIAS_BASE);

// local memories are 16 bits wide
assign mem_data = wdata[`CNN_MEM_W-1:0];

assign image_set_sel = awvalid && (awaddr == `CNN_IMAGE_SET_ADDR);
assign irq_clear     = awvalid && (awaddr == `CNN_IRQ_ADDR);

// image-set register
// a cpu write wins, otherwise a set value is cleared the next cycle
always_comb
begin
	if (image_set_sel)
	begin
		image_set_wr   = 1'b1;
		image_set_data = wdata[`CNN_IMAGE_SET_W-1:0];
	end
	else if (image_set_q != '0)
	begin
		image_set_wr   = 1'b1;
		image_set_data = '0;
	end
	else
	begin
		image_set_wr   = 1'b0;
		image_set_data = '0;
	end
end

endmodule

//--- verilog/pixel_store_seq.sv
`timescale 1ns/10ps
`include "cnn_load_macros.svh"

module pixel_store_seq
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  pixel_hit,
	input  logic [`CNN_MEM_W-1:0] mem_data,
	output logic                  pixel_wr,
	output logic [`CNN_MEM_W-1:0] pixel_addr,
	output logic [`CNN_MEM_W-1:0] pixel_data,
	output logic                  pixel_done
);

logic [`CNN_MEM_W-1:0] idx;
logic                  last_word;

assign last_word = (idx == `CNN_MEM_W'(`CNN_PIXEL_NUM - 1));

// every hit lands at the running index
assign pixel_wr   = pixel_hit;
assign pixel_addr = idx;
assign pixel_data = mem_data;
assign pixel_done = pixel_hit && last_word;

// wrap after a full image so the next one can be loaded
always_ff @(posedge clk or posedge rst)
begin
	if (rst)
	begin
		idx <= '0;
	end
	else if (pixel_hit)
	begin
		if (last_word)
		begin
			idx <= '0;
		end
		else
		begin
			idx <= idx + 1'b1;
		end
	end
end

endmodule

//--- verilog/weight_store_seq.sv
`timescale 1ns/10ps
`include "cnn_load_macros.svh"

module weight_store_seq
	import cnn_load_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  weight_hit,
	input  logic [`CNN_MEM_W-1:0] mem_data,
	output logic                  weight_wr,
	output logic                  l7_weight_wr,
	output logic [2:0]            l7_bank_sel,
	output logic [`CNN_MEM_W-1:0] weight_addr,
	output logic [`CNN_MEM_W-1:0] weight_data,
	output logic                  weight_done,
	output layer_id_e             weight_layer_sel
);

store_state_e          state;
logic [`CNN_MEM_W-1:0] idx;
logic [`CNN_MEM_W-1:0] last_idx;
logic                  active;
logic                  in_l7;
logic [2:0]            l7_bank;
logic [`CNN_MEM_W-1:0] l7_offset;

// last in-layer index per layer
always_comb
begin
	case (state)
		st_layer1:
		begin
			last_idx = `CNN_MEM_W'(`CNN_L1_WEIGHT_NUM - 1);
		end
		st_layer2:
		begin
			last_idx = `CNN_MEM_W'(`CNN_L2_WEIGHT_NUM - 1);
		end
		st_layer4:
		begin
			last_idx = `CNN_MEM_W'(`CNN_L4_WEIGHT_NUM - 1);
		end
		st_layer5:
		begin
			last_idx = `CNN_MEM_W'(`CNN_L5_WEIGHT_NUM - 1);
		end
		default:
		begin
			last_idx = `CNN_MEM_W'(`CNN_L7_WEIGHT_NUM - 1);
		end
	endcase
end

// layer 7 bank split, banks numbered from 1
// highest bank base not above the index wins
always_comb
begin
	l7_bank   = 3'd1;
	l7_offset = idx;
	for (int b = 1; b < `CNN_L7_BANK_NUM; b++)
	begin
		if (idx >= `CNN_MEM_W'(b * `CNN_L7_BANK_SIZE))
		begin
			l7_bank   = 3'(b + 1);
			l7_offset = idx - `CNN_MEM_W'(b * `CNN_L7_BANK_SIZE);
		end
	end
end

assign in_l7  = (state == st_layer7);
assign active = weight_hit && (state != st_finish);

// layers 1 to 5 share one memory, layer 7 has its own banks
assign weight_wr    = active && !in_l7;
assign l7_weight_wr = active && in_l7;
assign l7_bank_sel  = in_l7 ? l7_bank : 3'd0;
assign weight_addr  = in_l7 ? l7_offset : idx;
assign weight_data  = mem_data;
assign weight_done  = active && (idx == last_idx);

always_ff @(posedge clk or posedge rst)
begin
	if (rst)
	begin
		state            <= st_layer1;
		idx              <= '0;
		weight_layer_sel <= layer_none;
	end
	else if (weight_done)
	begin
		state            <= next_layer(state);
		idx              <= '0;
		weight_layer_sel <= state_layer(state);
	end
	else if (active)
	begin
		idx <= idx + 1'b1;
	end
end

endmodule
